//--- rtl/isaPkg.sv
package isaPkg;

	typedef logic [15:0] wordT;
	typedef logic [1:0] regIdxT;

	localparam int numRegs = 4;

	typedef enum logic [3:0] {
		opAdi = 4'd4,
		opOri = 4'd5,
		opLhi = 4'd6,
		opLwd = 4'd7,
		opSwd = 4'd8,
		opAlu = 4'd15
	} opcodeE;

	// function field of the ALU opcode
	typedef enum logic [5:0] {
		fnAdd = 6'd0,
		fnSub = 6'd1,
		fnAnd = 6'd2,
		fnOrr = 6'd3,
		fnNot = 6'd4,
		fnTcp = 6'd5,
		fnShl = 6'd6,
		fnShr = 6'd7,
		fnWwd = 6'd28,
		fnHlt = 6'd29
	} functE;

	// same 16 bits, register form or immediate form
	typedef union packed {
		struct packed {
			opcodeE opcode;
			regIdxT rs;
			regIdxT rt;
			regIdxT rd;
			functE funct;
		} rForm;
		struct packed {
			opcodeE opcode;
			regIdxT rs;
			regIdxT rt;
			logic [7:0] imm;
		} iForm;
	} instrU;

endpackage

//--- rtl/pipePkg.sv
package pipePkg;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOrr,
		aluNot,
		aluTcp,
		aluShl,
		aluShr
	} aluOpE;

	// where an execute operand comes from
	typedef enum logic [1:0] {
		fwdReg,
		fwdMem,
		fwdWb
	} fwdSelE;

	typedef struct packed {
		aluOpE aluOp;
		logic aluSrcImm; // operand B from immediate
		logic zeroA; // operand A forced to zero, LHI
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic isWwd;
		logic isHalt;
	} ctrlT;

endpackage

//--- rtl/pipeLinks.sv
interface idExLink;
	import isaPkg::*;
	import pipePkg::*;

	ctrlT ctrl;
	logic valid;
	regIdxT rs;
	regIdxT rt;
	regIdxT writeReg;
	wordT valA;
	wordT valB;
	wordT imm;

	modport src(output ctrl, valid, rs, rt, writeReg, valA, valB, imm);
	modport dst(input ctrl, valid, rs, rt, writeReg, valA, valB, imm);
endinterface

interface exMemLink;
	import isaPkg::*;
	import pipePkg::*;

	ctrlT ctrl;
	logic valid;
	wordT aluResult;
	wordT storeData;
	regIdxT writeReg;

	modport src(output ctrl, valid, aluResult, storeData, writeReg);
	modport dst(input ctrl, valid, aluResult, storeData, writeReg);
endinterface

interface memWbLink;
	import isaPkg::*;

	logic valid;
	logic regWrite;
	logic isWwd;
	logic isHalt;
	regIdxT writeReg;
	wordT result;

	modport src(output valid, regWrite, isWwd, isHalt, writeReg, result);
	modport dst(input valid, regWrite, isWwd, isHalt, writeReg, result);
	// execute taps the writeback value for forwarding
	modport fwd(input valid, regWrite, writeReg, result);
endinterface

//--- rtl/fetchStage.sv
module fetchStage #(
	parameter isaPkg::wordT resetPc = 16'h0000
) (
	input logic Clk,
	input logic arstN,
	input logic hold,
	output logic readM1,
	output isaPkg::wordT address1,
	input isaPkg::wordT data1,
	output isaPkg::instrU instr,
	output logic instrValid
);
	import isaPkg::*;

	wordT pc;
	logic running; // set one edge after reset release

	assign readM1 = running;
	assign address1 = pc;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			pc <= resetPc;
			running <= 1'b0;
			instrValid <= 1'b0;
		end else begin
			running <= 1'b1;
			if (!hold) begin
				instrValid <= running;
				if (running)
					pc <= pc + 16'd1;
			end
		end
	end

	// instruction word, frozen during a load-use stall
	always_ff @(posedge Clk) begin
		if (!hold)
			instr <= data1;
	end

endmodule

//--- rtl/decodeStage.sv
module decodeStage (
	input logic Clk,
	input logic arstN,
	input isaPkg::instrU instr,
	input logic instrValid,
	output logic hold,
	input logic wbWrite,
	input isaPkg::regIdxT wbReg,
	input isaPkg::wordT wbData,
	idExLink.src idEx
);
	import isaPkg::*;
	import pipePkg::*;

	wordT regFile [numRegs];
	opcodeE opcode;
	logic isAlu;
	regIdxT rs;
	regIdxT rt;
	regIdxT writeReg;
	logic usesRs;
	logic usesRt;
	logic halted;
	logic live;
	ctrlT ctrl;
	wordT immExt;
	wordT valA;
	wordT valB;

	assign opcode = instr.iForm.opcode;
	assign isAlu = (opcode == opAlu);
	assign rs = instr.iForm.rs; // same bits in both forms
	assign rt = instr.iForm.rt;
	assign writeReg = isAlu ? instr.rForm.rd : instr.iForm.rt;

	always_comb begin
		ctrl = '0; // add, no side effects
		immExt = '0;
		case (opcode)
			opAlu: begin
				ctrl.regWrite = 1'b1;
				case (instr.rForm.funct)
					fnAdd: ctrl.aluOp = aluAdd;
					fnSub: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOrr: ctrl.aluOp = aluOrr;
					fnNot: ctrl.aluOp = aluNot;
					fnTcp: ctrl.aluOp = aluTcp;
					fnShl: ctrl.aluOp = aluShl;
					fnShr: ctrl.aluOp = aluShr;
					fnWwd: begin
						ctrl.regWrite = 1'b0;
						ctrl.isWwd = 1'b1;
					end
					fnHlt: begin
						ctrl.regWrite = 1'b0;
						ctrl.isHalt = 1'b1;
					end
					default: ctrl.regWrite = 1'b0; // unknown funct, no-op
				endcase
			end
			opAdi: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				immExt = {{8{instr.iForm.imm[7]}}, instr.iForm.imm};
			end
			opOri: begin
				ctrl.aluOp = aluOrr;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				immExt = {8'h00, instr.iForm.imm};
			end
			opLhi: begin
				ctrl.zeroA = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				immExt = {instr.iForm.imm, 8'h00};
			end
			opLwd: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.regWrite = 1'b1;
				immExt = {{8{instr.iForm.imm[7]}}, instr.iForm.imm};
			end
			opSwd: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
				immExt = {{8{instr.iForm.imm[7]}}, instr.iForm.imm};
			end
			default: ; // unsupported opcode retires as no-op
		endcase
	end

	// load-use hazard against the instruction now in execute
	assign usesRs = (opcode != opLhi);
	assign usesRt = isAlu || (opcode == opSwd);
	assign live = instrValid && !halted;
	assign hold = live && idEx.valid && idEx.ctrl.memRead &&
		((usesRs && idEx.writeReg == rs) || (usesRt && idEx.writeReg == rt));

	// writeback in the same cycle wins over the stored value
	assign valA = (wbWrite && wbReg == rs) ? wbData : regFile[rs];
	assign valB = (wbWrite && wbReg == rt) ? wbData : regFile[rt];

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < numRegs; i++)
				regFile[i] <= '0;
		end else if (wbWrite) begin
			regFile[wbReg] <= wbData;
		end
	end

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			halted <= 1'b0;
			idEx.valid <= 1'b0;
			idEx.ctrl <= '0;
		end else begin
			idEx.valid <= live && !hold; // bubble on stall
			idEx.ctrl <= ctrl;
			if (live && !hold && ctrl.isHalt)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge Clk) begin
		idEx.rs <= rs;
		idEx.rt <= rt;
		idEx.writeReg <= writeReg;
		idEx.valA <= valA;
		idEx.valB <= valB;
		idEx.imm <= immExt;
	end

endmodule

//--- rtl/executeStage.sv
module executeStage (
	input logic Clk,
	input logic arstN,
	idExLink.dst idEx,
	exMemLink.src exMem,
	memWbLink.fwd memWb
);
	import isaPkg::*;
	import pipePkg::*;

	fwdSelE fwdA;
	fwdSelE fwdB;
	wordT regA;
	wordT regB;
	wordT opA;
	wordT opB;
	wordT aluResult;

	// youngest producer first
	function automatic fwdSelE pickSrc(input regIdxT src);
		if (exMem.valid && exMem.ctrl.regWrite && exMem.writeReg == src)
			return fwdMem;
		else if (memWb.valid && memWb.regWrite && memWb.writeReg == src)
			return fwdWb;
		return fwdReg;
	endfunction

	function automatic wordT pickVal(input fwdSelE sel, input wordT regVal);
		case (sel)
			fwdMem: return exMem.aluResult;
			fwdWb: return memWb.result;
			default: return regVal;
		endcase
	endfunction

	assign fwdA = pickSrc(idEx.rs);
	assign fwdB = pickSrc(idEx.rt);
	assign regA = pickVal(fwdA, idEx.valA);
	assign regB = pickVal(fwdB, idEx.valB);

	assign opA = idEx.ctrl.zeroA ? 16'h0000 : regA;

	always_comb begin
		if (idEx.ctrl.aluSrcImm)
			opB = idEx.imm;
		else if (idEx.ctrl.isWwd)
			opB = 16'h0000; // A + 0 passes rs through
		else
			opB = regB;
	end

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluAnd: aluResult = opA & opB;
			aluOrr: aluResult = opA | opB;
			aluNot: aluResult = ~opA;
			aluTcp: aluResult = ~opA + 16'd1;
			aluShl: aluResult = {opA[14:0], 1'b0};
			aluShr: aluResult = {opA[15], opA[15:1]}; // arithmetic
			default: aluResult = opA + opB;
		endcase
	end

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			exMem.valid <= 1'b0;
			exMem.ctrl <= '0;
		end else begin
			exMem.valid <= idEx.valid;
			exMem.ctrl <= idEx.ctrl;
		end
	end

	always_ff @(posedge Clk) begin
		exMem.aluResult <= aluResult;
		exMem.storeData <= regB; // forwarded rt
		exMem.writeReg <= idEx.writeReg;
	end

endmodule

//--- rtl/memoryStage.sv
module memoryStage (
	input logic Clk,
	input logic arstN,
	exMemLink.dst exMem,
	output logic readM2,
	output logic writeM2,
	output isaPkg::wordT address2,
	output isaPkg::wordT writeData2,
	input isaPkg::wordT readData2,
	memWbLink.src memWb
);
	import isaPkg::*;

	wordT result;

	assign readM2 = exMem.valid && exMem.ctrl.memRead;
	assign writeM2 = exMem.valid && exMem.ctrl.memWrite;
	assign address2 = exMem.aluResult;
	assign writeData2 = exMem.storeData;

	// memory answers in the same cycle
	assign result = exMem.ctrl.memRead ? readData2 : exMem.aluResult;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			memWb.valid <= 1'b0;
			memWb.regWrite <= 1'b0;
			memWb.isWwd <= 1'b0;
			memWb.isHalt <= 1'b0;
		end else begin
			memWb.valid <= exMem.valid;
			memWb.regWrite <= exMem.ctrl.regWrite;
			memWb.isWwd <= exMem.ctrl.isWwd;
			memWb.isHalt <= exMem.ctrl.isHalt;
		end
	end

	always_ff @(posedge Clk) begin
		memWb.writeReg <= exMem.writeReg;
		memWb.result <= result;
	end

endmodule

//--- rtl/writebackStage.sv
module writebackStage (
	input logic Clk,
	input logic arstN,
	memWbLink.dst memWb,
	output logic wbWrite,
	output isaPkg::regIdxT wbReg,
	output isaPkg::wordT wbData,
	output isaPkg::wordT numInst,
	output isaPkg::wordT outputPort,
	output logic isHalted
);

	// register write lands at the end of this cycle
	assign wbWrite = memWb.valid && memWb.regWrite;
	assign wbReg = memWb.writeReg;
	assign wbData = memWb.result;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			numInst <= 16'h0000;
			outputPort <= 16'h0000;
			isHalted <= 1'b0;
		end else if (memWb.valid) begin
			numInst <= numInst + 16'd1; // HLT counts too
			if (memWb.isWwd)
				outputPort <= memWb.result;
			if (memWb.isHalt)
				isHalted <= 1'b1;
		end
	end

endmodule

//--- rtl/cpu.sv
module cpu #(
	parameter isaPkg::wordT resetPc = 16'h0000
) (
	input logic Clk,
	input logic arstN,
	output logic readM1,
	output isaPkg::wordT address1,
	input isaPkg::wordT data1,
	output logic readM2,
	output logic writeM2,
	output isaPkg::wordT address2,
	output isaPkg::wordT writeData2,
	input isaPkg::wordT readData2,
	output isaPkg::wordT numInst,
	output isaPkg::wordT outputPort,
	output logic isHalted
);
	import isaPkg::*;

	instrU instr;
	logic instrValid;
	logic hold;
	logic wbWrite;
	regIdxT wbReg;
	wordT wbData;

	idExLink idEx();
	exMemLink exMem();
	memWbLink memWb();

	fetchStage #(
		.resetPc(resetPc)
	) fetch (
		.Clk(Clk),
		.arstN(arstN),
		.hold(hold),
		.readM1(readM1),
		.address1(address1),
		.data1(data1),
		.instr(instr),
		.instrValid(instrValid)
	);

	decodeStage decode (
		.Clk(Clk),
		.arstN(arstN),
		.instr(instr),
		.instrValid(instrValid),
		.hold(hold),
		.wbWrite(wbWrite),
		.wbReg(wbReg),
		.wbData(wbData),
		.idEx(idEx.src)
	);

	executeStage execute (
		.Clk(Clk),
		.arstN(arstN),
		.idEx(idEx.dst),
		.exMem(exMem.src),
		.memWb(memWb.fwd)
	);

	memoryStage memory (
		.Clk(Clk),
		.arstN(arstN),
		.exMem(exMem.dst),
		.readM2(readM2),
		.writeM2(writeM2),
		.address2(address2),
		.writeData2(writeData2),
		.readData2(readData2),
		.memWb(memWb.src)
	);

	writebackStage writeback (
		.Clk(Clk),
		.arstN(arstN),
		.memWb(memWb.dst),
		.wbWrite(wbWrite),
		.wbReg(wbReg),
		.wbData(wbData),
		.numInst(numInst),
		.outputPort(outputPort),
		.isHalted(isHalted)
	);

endmodule

//--- sim/cpuTb.sv
module cpuTb;
	import isaPkg::*;

	logic Clk;
	logic arstN;
	logic readM1;
	logic readM2;
	logic writeM2;
	logic isHalted;
	wordT address1;
	wordT data1;
	wordT address2;
	wordT writeData2;
	wordT readData2;
	wordT numInst;
	wordT outputPort;

	wordT imem [256];
	wordT dmem [256];
	wordT outLog [$]; // outputPort changes in order
	int progLen;
	int cycleCount;
	int cycleLimit;
	int writeCount;

	cpu #(
		.resetPc(16'h0000)
	) uut (
		.Clk(Clk),
		.arstN(arstN),
		.readM1(readM1),
		.address1(address1),
		.data1(data1),
		.readM2(readM2),
		.writeM2(writeM2),
		.address2(address2),
		.writeData2(writeData2),
		.readData2(readData2),
		.numInst(numInst),
		.outputPort(outputPort),
		.isHalted(isHalted)
	);

	initial Clk = 1'b0;
	always #10 Clk = ~Clk;

	// both memories answer in the same cycle as their strobe
	assign data1 = readM1 ? imem[address1[7:0]] : 16'hxxxx;
	assign readData2 = readM2 ? dmem[address2[7:0]] : 16'hxxxx;

	always @(posedge Clk) begin
		if (writeM2) begin
			dmem[address2[7:0]] <= writeData2;
			writeCount++;
		end
	end

	always @(posedge Clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit)
			abortRun($sformatf("timeout: the DUT did not halt within %0d cycles", cycleLimit));
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input wordT got, input wordT want);
		abortRun($sformatf("[FAIL] %s: got %h, expected %h", name, got, want));
	endtask

	function automatic wordT fillWord(input logic [7:0] addr);
		return {addr, ~addr};
	endfunction

	function automatic wordT rType(input functE fn, input regIdxT rs, input regIdxT rt,
		input regIdxT rd);
		return {opAlu, rs, rt, rd, fn};
	endfunction

	function automatic wordT iType(input opcodeE op, input regIdxT rs, input regIdxT rt,
		input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic clearMems();
		for (int i = 0; i < 256; i++) begin
			imem[i] = {8'h00, 8'(i)}; // opcode 0, retires as no-op
			dmem[i] = fillWord(8'(i));
		end
	endtask

	task automatic emit(input wordT w);
		imem[progLen] = w;
		progLen++;
	endtask

	// puts the DUT in reset and starts an empty program
	task automatic beginTest();
		cycleLimit += 20;
		@(posedge Clk);
		#2 arstN = 1'b0;
		clearMems();
		progLen = 0;
		writeCount = 0;
	endtask

	task automatic waitHalt();
		wordT last;
		outLog.delete();
		last = outputPort;
		while (!isHalted) begin
			@(negedge Clk);
			if (outputPort !== last) begin
				outLog.push_back(outputPort);
				last = outputPort;
			end
		end
	endtask

	task automatic runProgram();
		cycleLimit += 2 * progLen;
		repeat (4) @(posedge Clk);
		#2 arstN = 1'b1;
		waitHalt();
	endtask

	task automatic expectZero(input string name, input wordT value);
		assert (value == 16'h0000) else reportMismatch(name, value, 16'h0000);
	endtask

	// strobes and status over four cycles of reset
	task automatic checkResetOutputs();
		repeat (4) begin
			@(negedge Clk);
			expectZero("readM1", readM1);
			expectZero("readM2", readM2);
			expectZero("writeM2", writeM2);
			expectZero("numInst", numInst);
			expectZero("outputPort", outputPort);
			expectZero("isHalted", isHalted);
		end
	endtask

	task automatic verifyReset();
		beginTest();
		checkResetOutputs(); // power-on, nothing run yet
		emit(iType(opLhi, 2'd0, 2'd1, 8'h12));
		emit(rType(fnWwd, 2'd1, 2'd0, 2'd0));
		emit(rType(fnHlt, 2'd0, 2'd0, 2'd0));
		runProgram();
		assert (outputPort == 16'h1200) else reportMismatch("outputPort", outputPort, 16'h1200);
		@(posedge Clk);
		#2 arstN = 1'b0;
		checkResetOutputs();
	endtask

	task automatic aluChain();
		wordT a;
		wordT b;
		wordT want [9];
		a = $urandom;
		b = $urandom;
		beginTest();
		emit(iType(opLhi, 2'd0, 2'd1, a[15:8]));
		emit(iType(opOri, 2'd1, 2'd1, a[7:0]));
		emit(iType(opLhi, 2'd0, 2'd2, b[15:8]));
		emit(iType(opOri, 2'd2, 2'd2, b[7:0]));
		emit(rType(fnAdd, 2'd1, 2'd2, 2'd3));
		emit(iType(opSwd, 2'd0, 2'd3, 8'h40));
		emit(rType(fnSub, 2'd2, 2'd3, 2'd3));
		emit(iType(opSwd, 2'd0, 2'd3, 8'h41));
		emit(rType(fnAnd, 2'd3, 2'd1, 2'd3));
		emit(iType(opSwd, 2'd0, 2'd3, 8'h42));
		emit(rType(fnOrr, 2'd3, 2'd2, 2'd3));
		emit(iType(opSwd, 2'd0, 2'd3, 8'h43));
		emit(rType(fnNot, 2'd3, 2'd3, 2'd3));
		emit(iType(opSwd, 2'd0, 2'd3, 8'h44));
		emit(rType(fnTcp, 2'd3, 2'd3, 2'd3));
		emit(iType(opSwd, 2'd0, 2'd3, 8'h45));
		emit(rType(fnShl, 2'd3, 2'd3, 2'd3));
		emit(iType(opSwd, 2'd0, 2'd3, 8'h46));
		emit(rType(fnShr, 2'd3, 2'd3, 2'd3));
		emit(iType(opSwd, 2'd0, 2'd3, 8'h47));
		emit(iType(opAdi, 2'd3, 2'd3, 8'hF3)); // minus 13
		emit(iType(opSwd, 2'd0, 2'd3, 8'h48));
		emit(rType(fnHlt, 2'd0, 2'd0, 2'd0));
		want[0] = a + b;
		want[1] = b - want[0];
		want[2] = want[1] & a;
		want[3] = want[2] | b;
		want[4] = ~want[3];
		want[5] = 16'h0000 - want[4];
		want[6] = want[5] << 1;
		want[7] = $signed(want[6]) >>> 1;
		want[8] = want[7] - 16'd13;
		runProgram();
		for (int k = 0; k < 9; k++)
			assert (dmem[64 + k] == want[k])
				else reportMismatch($sformatf("dmem[%h]", 64 + k), dmem[64 + k], want[k]);
	endtask

	task automatic loadUseHazard();
		wordT p;
		wordT q;
		wordT want [4];
		p = $urandom;
		q = $urandom;
		beginTest();
		dmem[8'h20] = p;
		dmem[8'h21] = q;
		emit(iType(opLwd, 2'd0, 2'd1, 8'h20));
		emit(rType(fnAdd, 2'd1, 2'd1, 2'd2)); // stalls on r1
		emit(iType(opSwd, 2'd0, 2'd2, 8'h30));
		emit(iType(opLwd, 2'd0, 2'd3, 8'h21));
		emit(iType(opSwd, 2'd0, 2'd3, 8'h31)); // loaded value as store data
		emit(iType(opLwd, 2'd0, 2'd1, 8'h21));
		emit(iType(opAdi, 2'd1, 2'd2, 8'h05));
		emit(iType(opSwd, 2'd0, 2'd2, 8'h32));
		emit(iType(opLwd, 2'd0, 2'd3, 8'h20));
		emit(rType(fnAdd, 2'd2, 2'd3, 2'd1));
		emit(iType(opSwd, 2'd0, 2'd1, 8'h33));
		emit(rType(fnHlt, 2'd0, 2'd0, 2'd0));
		want[0] = p + p;
		want[1] = q;
		want[2] = q + 16'd5;
		want[3] = q + 16'd5 + p;
		runProgram();
		for (int k = 0; k < 4; k++)
			assert (dmem[48 + k] == want[k])
				else reportMismatch($sformatf("dmem[%h]", 48 + k), dmem[48 + k], want[k]);
		assert (numInst == 16'd12) else reportMismatch("numInst", numInst, 16'd12);
	endtask

	task automatic outputSequence();
		wordT rnd;
		wordT vals [4];
		beginTest();
		for (int k = 0; k < 4; k++) begin
			rnd = $urandom;
			vals[k] = {rnd[15:4], 4'(k + 1)}; // distinct and nonzero
			emit(iType(opLhi, 2'd0, 2'd1, vals[k][15:8]));
			emit(iType(opOri, 2'd1, 2'd1, vals[k][7:0]));
			emit(rType(fnWwd, 2'd1, 2'd0, 2'd0));
		end
		emit(rType(fnHlt, 2'd0, 2'd0, 2'd0));
		runProgram();
		assert (outLog.size() == 4)
			else reportMismatch("outputPort change count", 16'(outLog.size()), 16'd4);
		for (int k = 0; k < 4; k++)
			assert (outLog[k] == vals[k])
				else reportMismatch($sformatf("outputPort change %0d", k), outLog[k], vals[k]);
	endtask

	task automatic haltBehavior();
		beginTest();
		emit(rType(fnHlt, 2'd0, 2'd0, 2'd0));
		emit(iType(opSwd, 2'd0, 2'd1, 8'h50));
		emit(iType(opAdi, 2'd0, 2'd1, 8'h07));
		runProgram();
		repeat (8) begin
			@(negedge Clk);
			assert (isHalted) else abortRun("isHalted dropped after the halt");
		end
		assert (writeCount == 0) else abortRun("a store after HLT reached the data memory");
		assert (dmem[8'h50] == fillWord(8'h50))
			else reportMismatch("dmem[50]", dmem[8'h50], fillWord(8'h50));
		assert (numInst == 16'd1) else reportMismatch("numInst", numInst, 16'd1);
	endtask

	initial begin
		void'($urandom(32'h9297));
		arstN = 1'b0;
		cycleCount = 0;
		cycleLimit = 0;
		writeCount = 0;
		progLen = 0;
		clearMems();
		verifyReset();
		aluChain();
		loadUseHazard();
		outputSequence();
		haltBehavior();
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- list.f
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/pipeLinks.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/writebackStage.sv
rtl/cpu.sv
sim/cpuTb.sv
